//--- design/lsu_pkg.sv
package lsu_pkg;

	// widths of the single AXI4-Lite port
	localparam int AXI_ADDR_W = 32;
	localparam int AXI_DATA_W = 32;
	localparam int AXI_STRB_W = AXI_DATA_W / 8;

	// load/store opcodes as issued by the core
	typedef enum logic [2:0] {
		NONE = 3'd0,
		LB   = 3'd1,
		LH   = 3'd2,
		LW   = 3'd3,
		SB   = 3'd4,
		SH   = 3'd5,
		SW   = 3'd6
	} lsu_op_e;

	// one-cycle command strobe from the core
	typedef struct packed {
		lsu_op_e                 op;
		// byte address
		logic [AXI_ADDR_W-1:0]   addr;
		// store data in the low bits
		logic [AXI_DATA_W-1:0]   wdata;
	} lsu_cmd_t;

	// response back to the core
	typedef struct packed {
		// single-cycle pulse
		logic                    done;
		logic                    is_load;
		logic                    err;
		// sign-extended load value or zero for stores
		logic [AXI_DATA_W-1:0]   rdata;
	} lsu_rsp_t;

	// what the formatter needs to know about an outstanding load
	typedef struct packed {
		// 0001 byte, 0011 half, 1111 word
		logic [AXI_STRB_W-1:0]   size_mask;
		// byte lane inside the word
		logic [1:0]              offset;
		logic                    valid;
	} load_tag_t;

endpackage

//--- design/axi_lite_master.sv
`timescale 1ns/1ps

module axi_lite_master (
	input  logic                            axi_aclk_i,
	input  logic                            axi_aresetn_i,

	input  lsu_pkg::lsu_cmd_t               cmd_i,
	output logic                            busy_o,

	// read address / read data
	output logic [lsu_pkg::AXI_ADDR_W-1:0]  axi_araddr_o,
	output logic                            axi_arvalid_o,
	input  logic                            axi_arready_i,
	input  logic                            axi_rvalid_i,
	output logic                            axi_rready_o,
	input  logic [lsu_pkg::AXI_DATA_W-1:0]  axi_rdata_i,
	input  logic                            axi_rresp_i,

	// write address / write data / response
	output logic [lsu_pkg::AXI_ADDR_W-1:0]  axi_awaddr_o,
	output logic                            axi_awvalid_o,
	input  logic                            axi_awready_i,
	output logic [lsu_pkg::AXI_DATA_W-1:0]  axi_wdata_o,
	output logic [lsu_pkg::AXI_STRB_W-1:0]  axi_wstrb_o,
	output logic                            axi_wvalid_o,
	input  logic                            axi_wready_i,
	input  logic                            axi_bvalid_i,
	output logic                            axi_bready_o,
	input  logic                            axi_bresp_i,

	// towards the load formatter
	output lsu_pkg::load_tag_t              load_tag_o,
	output logic                            r_done_o,
	output logic                            b_done_o,
	output logic                            resp_ok_o,
	output logic [lsu_pkg::AXI_DATA_W-1:0]  rdata_o
);

	import lsu_pkg::*;

	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		READ  = 2'd1,
		WRITE = 2'd2
	} state_e;

	state_e                state_q;
	logic                  is_rd;
	logic                  is_wr;
	logic                  accept;
	logic [AXI_STRB_W-1:0] size_mask;
	logic [AXI_ADDR_W-1:0] addr_q;
	logic                  tag_valid_q;
	logic [AXI_STRB_W-1:0] tag_size_q;
	logic [1:0]            tag_offset_q;
	logic                  ar_hs;
	logic                  aw_hs;

	// opcode decode
	always_comb begin
		is_rd = 1'b0;
		is_wr = 1'b0;
		size_mask = '0;
		case (cmd_i.op)
			LB: begin
				is_rd = 1'b1;
				size_mask = 4'b0001;
			end
			LH: begin
				is_rd = 1'b1;
				size_mask = 4'b0011;
			end
			LW: begin
				is_rd = 1'b1;
				size_mask = 4'b1111;
			end
			SB: begin
				is_wr = 1'b1;
				size_mask = 4'b0001;
			end
			SH: begin
				is_wr = 1'b1;
				size_mask = 4'b0011;
			end
			SW: begin
				is_wr = 1'b1;
				size_mask = 4'b1111;
			end
			default: begin
			end
		endcase
	end

	// new commands only land while idle
	assign accept = (state_q == IDLE) && (is_rd || is_wr);
	assign ar_hs  = axi_arvalid_o && axi_arready_i;
	assign aw_hs  = axi_awvalid_o && axi_awready_i && axi_wvalid_o && axi_wready_i;

	always_ff @(posedge axi_aclk_i) begin
		if (axi_aresetn_i) begin
			state_q       <= IDLE;
			axi_arvalid_o <= 1'b0;
			axi_awvalid_o <= 1'b0;
			axi_wvalid_o  <= 1'b0;
			axi_rready_o  <= 1'b0;
			axi_bready_o  <= 1'b0;
			tag_valid_q   <= 1'b0;
		end else begin
			// always ready for responses once out of reset
			axi_rready_o <= 1'b1;
			axi_bready_o <= 1'b1;
			case (state_q)
				IDLE: begin
					if (accept && is_rd) begin
						state_q       <= READ;
						axi_arvalid_o <= 1'b1;
						tag_valid_q   <= 1'b1;
					end else if (accept) begin
						state_q       <= WRITE;
						axi_awvalid_o <= 1'b1;
						axi_wvalid_o  <= 1'b1;
					end
				end
				READ: begin
					if (ar_hs)
						axi_arvalid_o <= 1'b0;
					if (r_done_o) begin
						state_q     <= IDLE;
						tag_valid_q <= 1'b0;
					end
				end
				WRITE: begin
					// aw and w complete together
					if (aw_hs) begin
						axi_awvalid_o <= 1'b0;
						axi_wvalid_o  <= 1'b0;
					end
					if (b_done_o)
						state_q <= IDLE;
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// address, lane-shifted data and strobes
	always_ff @(posedge axi_aclk_i) begin
		if (accept) begin
			addr_q       <= cmd_i.addr;
			axi_wdata_o  <= cmd_i.wdata << {cmd_i.addr[1:0], 3'b000};
			axi_wstrb_o  <= size_mask << cmd_i.addr[1:0];
			tag_size_q   <= size_mask;
			tag_offset_q <= cmd_i.addr[1:0];
		end
	end

	assign axi_araddr_o = addr_q;
	assign axi_awaddr_o = addr_q;
	assign busy_o       = (state_q != IDLE);

	assign load_tag_o = '{size_mask: tag_size_q, offset: tag_offset_q, valid: tag_valid_q};

	// raw channel events for the formatter
	assign r_done_o  = axi_rvalid_i && axi_rready_o && (state_q == READ);
	assign b_done_o  = axi_bvalid_i && axi_bready_o && (state_q == WRITE);
	assign resp_ok_o = r_done_o ? axi_rresp_i : axi_bresp_i;
	assign rdata_o   = axi_rdata_i;

	// read request must not change or drop before the slave takes it
	ar_stable_a: assert property (@(posedge axi_aclk_i) disable iff (axi_aresetn_i)
		(axi_arvalid_o && !axi_arready_i) |=> (axi_arvalid_o && $stable(axi_araddr_o)));

endmodule

//--- design/load_formatter.sv
`timescale 1ns/1ps

module load_formatter (
	input  logic                            axi_aclk_i,
	input  logic                            axi_aresetn_i,
	input  lsu_pkg::load_tag_t              load_tag_i,
	input  logic                            r_done_i,
	input  logic                            b_done_i,
	input  logic                            resp_ok_i,
	input  logic [lsu_pkg::AXI_DATA_W-1:0]  rdata_i,
	output lsu_pkg::lsu_rsp_t               rsp_o
);

	import lsu_pkg::*;

	logic                  rd_fire;
	logic [AXI_DATA_W-1:0] lane;
	logic [AXI_DATA_W-1:0] load_val;
	logic                  done_q;
	logic                  is_load_q;
	logic                  err_q;
	logic [AXI_DATA_W-1:0] rdata_q;

	assign rd_fire = r_done_i && load_tag_i.valid;

	// bring the addressed lane down to bit 0, then sign-extend
	always_comb begin
		lane = rdata_i >> {load_tag_i.offset, 3'b000};
		case (load_tag_i.size_mask)
			4'b0001: load_val = {{(AXI_DATA_W-8){lane[7]}}, lane[7:0]};
			4'b0011: load_val = {{(AXI_DATA_W-16){lane[15]}}, lane[15:0]};
			default: load_val = lane;
		endcase
	end

	always_ff @(posedge axi_aclk_i) begin
		if (axi_aresetn_i)
			done_q <= 1'b0;
		else
			done_q <= rd_fire || b_done_i;
	end

	always_ff @(posedge axi_aclk_i) begin
		if (rd_fire) begin
			is_load_q <= 1'b1;
			err_q     <= !resp_ok_i;
			rdata_q   <= load_val;
		end else if (b_done_i) begin
			// stores report status only
			is_load_q <= 1'b0;
			err_q     <= !resp_ok_i;
			rdata_q   <= '0;
		end
	end

	assign rsp_o = '{done: done_q, is_load: is_load_q, err: err_q, rdata: rdata_q};

	// one transaction at a time, so the two channels never finish together
	one_done_a: assert property (@(posedge axi_aclk_i) disable iff (axi_aresetn_i)
		!(r_done_i && b_done_i));

	// a read completion always has a tag captured by the master
	tag_valid_a: assert property (@(posedge axi_aclk_i) disable iff (axi_aresetn_i)
		r_done_i |-> load_tag_i.valid);

endmodule

//--- design/axi_lite_ram.sv
`timescale 1ns/1ps

module axi_lite_ram #(
	parameter int DEPTH_WORDS = 256,
	parameter int RAM_WAIT    = 2
) (
	input  logic                            axi_aclk_i,
	input  logic                            axi_aresetn_i,

	input  logic [lsu_pkg::AXI_ADDR_W-1:0]  axi_araddr_i,
	input  logic                            axi_arvalid_i,
	output logic                            axi_arready_o,
	output logic                            axi_rvalid_o,
	input  logic                            axi_rready_i,
	output logic [lsu_pkg::AXI_DATA_W-1:0]  axi_rdata_o,
	output logic                            axi_rresp_o,

	input  logic [lsu_pkg::AXI_ADDR_W-1:0]  axi_awaddr_i,
	input  logic                            axi_awvalid_i,
	output logic                            axi_awready_o,
	input  logic [lsu_pkg::AXI_DATA_W-1:0]  axi_wdata_i,
	input  logic [lsu_pkg::AXI_STRB_W-1:0]  axi_wstrb_i,
	input  logic                            axi_wvalid_i,
	output logic                            axi_wready_o,
	output logic                            axi_bvalid_o,
	input  logic                            axi_bready_i,
	output logic                            axi_bresp_o
);

	import lsu_pkg::*;

	localparam int IDX_W = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;
	localparam int CNT_W = (RAM_WAIT > 0) ? $clog2(RAM_WAIT + 1) : 1;

	logic [AXI_DATA_W-1:0] mem [DEPTH_WORDS];

	logic [CNT_W-1:0]      wait_cnt;
	logic                  resp_busy;
	logic                  rd_req;
	logic                  wr_req;
	logic                  wait_done;
	logic                  rd_go;
	logic                  wr_go;
	logic [AXI_ADDR_W-3:0] rd_word;
	logic [AXI_ADDR_W-3:0] wr_word;
	logic                  rd_ok;
	logic                  wr_ok;

	// word index from byte address
	assign rd_word = axi_araddr_i[AXI_ADDR_W-1:2];
	assign wr_word = axi_awaddr_i[AXI_ADDR_W-1:2];
	assign rd_ok   = (rd_word < DEPTH_WORDS);
	assign wr_ok   = (wr_word < DEPTH_WORDS);

	// no new access while a response is still pending; reads win
	assign resp_busy = axi_rvalid_o || axi_bvalid_o;
	assign rd_req    = axi_arvalid_i && !resp_busy;
	assign wr_req    = axi_awvalid_i && axi_wvalid_i && !resp_busy && !axi_arvalid_i;
	assign wait_done = (wait_cnt == CNT_W'(RAM_WAIT));

	assign rd_go = rd_req && wait_done;
	assign wr_go = wr_req && wait_done;

	assign axi_arready_o = rd_go;
	assign axi_awready_o = wr_go;
	assign axi_wready_o  = wr_go;

	// wait states before ready
	always_ff @(posedge axi_aclk_i) begin
		if (axi_aresetn_i)
			wait_cnt <= '0;
		else if (rd_go || wr_go || !(rd_req || wr_req))
			wait_cnt <= '0;
		else
			wait_cnt <= wait_cnt + CNT_W'(1);
	end

	always_ff @(posedge axi_aclk_i) begin
		if (axi_aresetn_i) begin
			axi_rvalid_o <= 1'b0;
			axi_bvalid_o <= 1'b0;
		end else begin
			if (rd_go)
				axi_rvalid_o <= 1'b1;
			else if (axi_rready_i)
				axi_rvalid_o <= 1'b0;
			if (wr_go)
				axi_bvalid_o <= 1'b1;
			else if (axi_bready_i)
				axi_bvalid_o <= 1'b0;
		end
	end

	// read data and status with 1 meaning ok
	always_ff @(posedge axi_aclk_i) begin
		if (rd_go) begin
			axi_rresp_o <= rd_ok;
			axi_rdata_o <= rd_ok ? mem[rd_word[IDX_W-1:0]] : '0;
		end
		if (wr_go)
			axi_bresp_o <= wr_ok;
	end

	// byte-strobed write that drops out of range addresses
	always_ff @(posedge axi_aclk_i) begin
		if (wr_go && wr_ok) begin
			for (int i = 0; i < AXI_STRB_W; i++) begin
				if (axi_wstrb_i[i])
					mem[wr_word[IDX_W-1:0]][i*8 +: 8] <= axi_wdata_i[i*8 +: 8];
			end
		end
	end

	// a write response only appears after an accepted write
	b_after_w_a: assert property (@(posedge axi_aclk_i) disable iff (axi_aresetn_i)
		$rose(axi_bvalid_o) |-> $past(axi_awvalid_i && axi_awready_o && axi_wvalid_i));

endmodule

//--- design/lsu_axi_top.sv
`timescale 1ns/1ps

module lsu_axi_top #(
	parameter int DEPTH_WORDS = 256,
	parameter int RAM_WAIT    = 2
) (
	input  logic               axi_aclk_i,
	input  logic               axi_aresetn_i,
	input  lsu_pkg::lsu_cmd_t  cmd_i,
	output logic               busy_o,
	output lsu_pkg::lsu_rsp_t  rsp_o
);

	import lsu_pkg::*;

	// AXI4-Lite bus between master and RAM
	logic [AXI_ADDR_W-1:0] araddr;
	logic                  arvalid;
	logic                  arready;
	logic                  rvalid;
	logic                  rready;
	logic [AXI_DATA_W-1:0] rdata;
	logic                  rresp;
	logic [AXI_ADDR_W-1:0] awaddr;
	logic                  awvalid;
	logic                  awready;
	logic [AXI_DATA_W-1:0] wdata;
	logic [AXI_STRB_W-1:0] wstrb;
	logic                  wvalid;
	logic                  wready;
	logic                  bvalid;
	logic                  bready;
	logic                  bresp;

	// master to formatter
	load_tag_t             load_tag;
	logic                  r_done;
	logic                  b_done;
	logic                  resp_ok;
	logic [AXI_DATA_W-1:0] raw_rdata;

	axi_lite_master u_master (
		.axi_aclk_i    (axi_aclk_i),
		.axi_aresetn_i (axi_aresetn_i),
		.cmd_i         (cmd_i),
		.busy_o        (busy_o),
		.axi_araddr_o  (araddr),
		.axi_arvalid_o (arvalid),
		.axi_arready_i (arready),
		.axi_rvalid_i  (rvalid),
		.axi_rready_o  (rready),
		.axi_rdata_i   (rdata),
		.axi_rresp_i   (rresp),
		.axi_awaddr_o  (awaddr),
		.axi_awvalid_o (awvalid),
		.axi_awready_i (awready),
		.axi_wdata_o   (wdata),
		.axi_wstrb_o   (wstrb),
		.axi_wvalid_o  (wvalid),
		.axi_wready_i  (wready),
		.axi_bvalid_i  (bvalid),
		.axi_bready_o  (bready),
		.axi_bresp_i   (bresp),
		.load_tag_o    (load_tag),
		.r_done_o      (r_done),
		.b_done_o      (b_done),
		.resp_ok_o     (resp_ok),
		.rdata_o       (raw_rdata)
	);

	load_formatter u_formatter (
		.axi_aclk_i    (axi_aclk_i),
		.axi_aresetn_i (axi_aresetn_i),
		.load_tag_i    (load_tag),
		.r_done_i      (r_done),
		.b_done_i      (b_done),
		.resp_ok_i     (resp_ok),
		.rdata_i       (raw_rdata),
		.rsp_o         (rsp_o)
	);

	axi_lite_ram #(
		.DEPTH_WORDS (DEPTH_WORDS),
		.RAM_WAIT    (RAM_WAIT)
	) u_ram (
		.axi_aclk_i    (axi_aclk_i),
		.axi_aresetn_i (axi_aresetn_i),
		.axi_araddr_i  (araddr),
		.axi_arvalid_i (arvalid),
		.axi_arready_o (arready),
		.axi_rvalid_o  (rvalid),
		.axi_rready_i  (rready),
		.axi_rdata_o   (rdata),
		.axi_rresp_o   (rresp),
		.axi_awaddr_i  (awaddr),
		.axi_awvalid_i (awvalid),
		.axi_awready_o (awready),
		.axi_wdata_i   (wdata),
		.axi_wstrb_i   (wstrb),
		.axi_wvalid_i  (wvalid),
		.axi_wready_o  (wready),
		.axi_bvalid_o  (bvalid),
		.axi_bready_i  (bready),
		.axi_bresp_o   (bresp)
	);

endmodule

//--- testbench/tb_lsu_axi_top.sv
`timescale 1ns/1ps

module tb_lsu_axi_top;

	import lsu_pkg::*;

	localparam int DEPTH_WORDS = 64;
	localparam int RAM_WAIT    = 2;
	localparam int MEM_BYTES   = DEPTH_WORDS * 4;
	localparam int TIMEOUT     = 100;

	logic       axi_aclk;
	logic       axi_aresetn;
	lsu_cmd_t   cmd;
	logic       busy;
	lsu_rsp_t   rsp;

	// byte-wide reference image of the RAM
	logic [7:0] model_mem [MEM_BYTES];
	int         error_count;
	int         check_count;
	lsu_rsp_t   last_rsp;

	always #4 axi_aclk = ~axi_aclk;

	lsu_axi_top #(
		.DEPTH_WORDS (DEPTH_WORDS),
		.RAM_WAIT    (RAM_WAIT)
	) u_lsu_axi_top (
		.axi_aclk_i    (axi_aclk),
		.axi_aresetn_i (axi_aresetn),
		.cmd_i         (cmd),
		.busy_o        (busy),
		.rsp_o         (rsp)
	);

	// little-endian lane pick and sign extension from the model
	function automatic logic [31:0] expected_load(lsu_op_e op, logic [31:0] addr);
		logic [31:0] word;
		int          base;
		base = int'(addr);
		case (op)
			LB: word = {{24{model_mem[base][7]}}, model_mem[base]};
			LH: word = {{16{model_mem[base+1][7]}}, model_mem[base+1], model_mem[base]};
			default: word = {model_mem[base+3], model_mem[base+2],
				model_mem[base+1], model_mem[base]};
		endcase
		return word;
	endfunction

	// whole address feeds the pattern
	function automatic logic [31:0] fill_word(logic [31:0] addr);
		return (addr * 32'h9e3779b1) ^ 32'h5a5a5a5a;
	endfunction

	task automatic model_store(lsu_op_e op, logic [31:0] addr, logic [31:0] data);
		int nbytes;
		nbytes = (op == SB) ? 1 : ((op == SH) ? 2 : 4);
		for (int i = 0; i < nbytes; i++)
			model_mem[int'(addr) + i] = data[i*8 +: 8];
	endtask

	task automatic finish_run();
		$display("checks: %0d  errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	endtask

	task automatic check_word(string what, logic [31:0] got, logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAIL %0t ns: %s got %08h expected %08h", $time, what, got, exp);
		end
	endtask

	task automatic check_bit(string what, logic got, logic exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAIL %0t ns: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	// one-cycle command strobe, then wait for the done pulse
	task automatic issue_cmd(lsu_op_e op, logic [31:0] addr, logic [31:0] wdata);
		int waited;
		@(negedge axi_aclk);
		cmd.op    = op;
		cmd.addr  = addr;
		cmd.wdata = wdata;
		@(negedge axi_aclk);
		cmd.op = NONE;
		waited = 0;
		while (!rsp.done && waited < TIMEOUT) begin
			@(negedge axi_aclk);
			waited++;
		end
		if (!rsp.done) begin
			error_count++;
			$display("no response within %0d cycles to %s at address %08h",
				TIMEOUT, op.name(), addr);
			finish_run();
		end
		last_rsp = rsp;
	endtask

	task automatic do_load(lsu_op_e op, logic [31:0] addr);
		string what;
		what = $sformatf("%s @%08h", op.name(), addr);
		issue_cmd(op, addr, 32'h0);
		check_bit({what, " is_load"}, last_rsp.is_load, 1'b1);
		check_bit({what, " err"}, last_rsp.err, 1'b0);
		check_word({what, " rdata"}, last_rsp.rdata, expected_load(op, addr));
	endtask

	task automatic do_store(lsu_op_e op, logic [31:0] addr, logic [31:0] data);
		string what;
		what = $sformatf("%s @%08h", op.name(), addr);
		issue_cmd(op, addr, data);
		check_bit({what, " is_load"}, last_rsp.is_load, 1'b0);
		check_bit({what, " err"}, last_rsp.err, 1'b0);
		check_word({what, " rdata"}, last_rsp.rdata, 32'h0);
		model_store(op, addr, data);
	endtask

	task automatic test_reset();
		check_bit("busy_o after reset", busy, 1'b0);
		check_bit("rsp_o.done after reset", rsp.done, 1'b0);
		do_store(SW, 32'h10, 32'hdeadbeef);
		do_load(LW, 32'h10);
	endtask

	task automatic fill_memory();
		for (int w = 0; w < DEPTH_WORDS; w++)
			do_store(SW, w * 4, fill_word(w * 4));
	endtask

	task automatic test_sub_word_stores();
		logic [31:0] base;
		base = 32'h40;
		for (int off = 0; off < 4; off++) begin
			do_store(SB, base + off, $urandom);
			do_load(LW, base);
		end
		for (int off = 0; off < 4; off += 2) begin
			do_store(SH, base + off, $urandom);
			do_load(LW, base);
		end
	endtask

	task automatic test_sign_extend();
		logic [31:0] base;
		logic [31:0] word;
		base = 32'h60;
		for (int k = 0; k < 4; k++) begin
			word = $urandom;
			// alternate all lanes negative and all lanes positive
			if (k[0])
				word = word | 32'h80808080;
			else
				word = word & 32'h7f7f7f7f;
			do_store(SW, base, word);
			for (int off = 0; off < 4; off++)
				do_load(LB, base + off);
			do_load(LH, base);
			do_load(LH, base + 2);
		end
	endtask

	task automatic test_out_of_range();
		logic [31:0] bad;
		bad = MEM_BYTES + 32'h20;
		issue_cmd(LW, bad, 32'h0);
		check_bit("LW out of range err", last_rsp.err, 1'b1);
		check_bit("LW out of range is_load", last_rsp.is_load, 1'b1);
		check_word("LW out of range rdata", last_rsp.rdata, 32'h0);
		issue_cmd(SW, bad, 32'hffffffff);
		check_bit("SW out of range err", last_rsp.err, 1'b1);
		check_bit("SW out of range is_load", last_rsp.is_load, 1'b0);
		issue_cmd(LB, 32'h8000_0001, 32'h0);
		check_bit("LB far address err", last_rsp.err, 1'b1);
		// the aliased in-range word keeps its old contents
		do_load(LW, bad % MEM_BYTES);
	endtask

	task automatic test_busy_ignore();
		int done_count;
		@(negedge axi_aclk);
		cmd.op    = SW;
		cmd.addr  = 32'h80;
		cmd.wdata = 32'h1234abcd;
		@(negedge axi_aclk);
		if (!busy) begin
			error_count++;
			$display("busy_o did not rise after the first command was accepted");
		end
		cmd.op    = SW;
		cmd.addr  = 32'h84;
		cmd.wdata = 32'hcafef00d;
		@(negedge axi_aclk);
		cmd.op = NONE;
		done_count = 0;
		for (int c = 0; c < 40; c++) begin
			@(negedge axi_aclk);
			if (rsp.done)
				done_count++;
		end
		check_word("done pulses for two overlapping commands", done_count, 1);
		model_store(SW, 32'h80, 32'h1234abcd);
		do_load(LW, 32'h80);
		do_load(LW, 32'h84);
	endtask

	task automatic test_random();
		logic [31:0] sel;
		logic [31:0] addr;
		lsu_op_e     op;
		for (int n = 0; n < 40; n++) begin
			sel  = $urandom % 6;
			op   = lsu_op_e'(sel[2:0] + 3'd1);
			addr = ($urandom % DEPTH_WORDS) * 4;
			if (op == LB || op == SB)
				addr = addr + ($urandom % 4);
			else if (op == LH || op == SH)
				addr = addr + ($urandom % 2) * 2;
			if (op == SB || op == SH || op == SW)
				do_store(op, addr, $urandom);
			else
				do_load(op, addr);
		end
	endtask

	initial begin
		int seed_ret;
		seed_ret    = $urandom(32'h31f4);
		error_count = 0;
		check_count = 0;
		axi_aclk    = 1'b0;
		axi_aresetn = 1'b1;
		cmd         = '0;
		cmd.op      = NONE;
		repeat (4) @(posedge axi_aclk);
		@(negedge axi_aclk);
		axi_aresetn = 1'b0;

		test_reset();
		fill_memory();
		test_sub_word_stores();
		test_sign_extend();
		test_out_of_range();
		test_busy_ignore();
		test_random();
		finish_run();
	end

endmodule

//--- vlog.f
design/lsu_pkg.sv
design/axi_lite_master.sv
design/load_formatter.sv
design/axi_lite_ram.sv
design/lsu_axi_top.sv
testbench/tb_lsu_axi_top.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module tb_lsu_axi_top -o Vtb_lsu_axi_top || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vtb_lsu_axi_top)
echo "$out"
echo "$out" | grep -q "^=== PASS ===$" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
